//--- rtl/fft_stage_cfg_pkg.sv
package fft_stage_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Component widths
  ////////////////////////////////////////////////////////////
  localparam int W_IN  = 21;  // Q6.15 input samples
  localparam int W_BF  = 22;  // Q7.15 after one bit of butterfly growth
  localparam int W_OUT = 10;  // Q6.4 output samples

  // Fraction bits of each format
  localparam int FRAC_IN  = 15;
  localparam int FRAC_OUT = 4;
  localparam int SHIFT    = FRAC_IN - FRAC_OUT;

  // Output saturation limits
  localparam logic signed [W_OUT-1:0] OUT_MAX = {1'b0, {(W_OUT-1){1'b1}}};
  localparam logic signed [W_OUT-1:0] OUT_MIN = {1'b1, {(W_OUT-1){1'b0}}};

  ////////////////////////////////////////////////////////////
  // Commutator timing
  ////////////////////////////////////////////////////////////
  localparam int COMM_DEPTH = 16;
  localparam int CNT_W      = $clog2(COMM_DEPTH);
  // Butterfly register plus output register
  localparam int PIPE_TAIL  = 2;

endpackage

//--- rtl/fft_types_pkg.sv
package fft_types_pkg;

  import fft_stage_cfg_pkg::*;

  ////////////////////////////////////////////////////////////
  // Complex samples at each precision
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic signed [W_IN-1:0] re;
    logic signed [W_IN-1:0] im;
  } cplx_in_t;

  typedef struct packed {
    logic signed [W_BF-1:0] re;
    logic signed [W_BF-1:0] im;
  } cplx_bf_t;

  typedef struct packed {
    logic signed [W_OUT-1:0] re;
    logic signed [W_OUT-1:0] im;
  } cplx_out_t;

  ////////////////////////////////////////////////////////////
  // Lane ports carrying one up and one down sample per clock
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    cplx_in_t up;
    cplx_in_t down;
  } lane_in_t;

  typedef struct packed {
    cplx_out_t up;
    cplx_out_t down;
  } lane_out_t;

endpackage

//--- rtl/delay_line.sv
module delay_line #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk,
  input  logic rst,
  input  T     d,
  output T     q
);

  // One entry per clock of delay
  T stages [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else begin
      stages[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  // Oldest entry
  assign q = stages[DEPTH-1];

endmodule

//--- rtl/commutator_ctrl.sv
module commutator_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic in_enable,
  output logic swap,
  output logic out_valid
);

  import fft_stage_cfg_pkg::*;

  logic             start_clr;
  logic             en_dly;
  logic [CNT_W-1:0] phase_cnt;

  ////////////////////////////////////////////////////////////
  // Start-up delay
  ////////////////////////////////////////////////////////////
  // Cleared whenever the stream pauses, so en_dly only rises after
  // COMM_DEPTH consecutive enabled cycles
  assign start_clr = rst || !in_enable;

  delay_line #(
    .T     (logic),
    .DEPTH (COMM_DEPTH)
  ) start_dly_i (
    .clk (clk),
    .rst (start_clr),
    .d   (in_enable),
    .q   (en_dly)
  );

  ////////////////////////////////////////////////////////////
  // Switch phase
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || !in_enable) begin
      phase_cnt <= '0;
      swap      <= 1'b0;
    end else if (en_dly) begin
      phase_cnt <= phase_cnt + 1'b1;
      // Toggle at the wrap
      if (phase_cnt == CNT_W'(COMM_DEPTH - 1)) begin
        swap <= ~swap;
      end
    end
  end

  // Valid follows the enable through the whole lane latency
  delay_line #(
    .T     (logic),
    .DEPTH (COMM_DEPTH + PIPE_TAIL)
  ) valid_dly_i (
    .clk (clk),
    .rst (rst),
    .d   (in_enable),
    .q   (out_valid)
  );

endmodule

//--- rtl/delay_commutator.sv
module delay_commutator (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   swap,
  input  fft_types_pkg::lane_in_t din,
  output fft_types_pkg::cplx_in_t x,
  output fft_types_pkg::cplx_in_t y
);

  import fft_stage_cfg_pkg::*;
  import fft_types_pkg::*;

  cplx_in_t up_dly;
  cplx_in_t up_path;
  cplx_in_t low_path;

  ////////////////////////////////////////////////////////////
  // Input side delay of the up stream
  ////////////////////////////////////////////////////////////
  delay_line #(
    .T     (cplx_in_t),
    .DEPTH (COMM_DEPTH)
  ) up_in_dly_i (
    .clk (clk),
    .rst (rst),
    .d   (din.up),
    .q   (up_dly)
  );

  // Switch
  always_comb begin
    if (swap) begin
      up_path  = din.down;
      low_path = up_dly;
    end else begin
      up_path  = up_dly;
      low_path = din.down;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output side delay of the up path
  ////////////////////////////////////////////////////////////
  delay_line #(
    .T     (cplx_in_t),
    .DEPTH (COMM_DEPTH)
  ) up_out_dly_i (
    .clk (clk),
    .rst (rst),
    .d   (up_path),
    .q   (x)
  );

  // Low path goes straight to the butterfly
  assign y = low_path;

endmodule

//--- rtl/bfly_r2.sv
module bfly_r2 (
  input  logic                   clk,
  input  logic                   rst,
  input  fft_types_pkg::cplx_in_t x,
  input  fft_types_pkg::cplx_in_t y,
  output fft_types_pkg::cplx_bf_t sum,
  output fft_types_pkg::cplx_bf_t diff
);

  import fft_stage_cfg_pkg::*;

  logic signed [W_BF-1:0] x_re;
  logic signed [W_BF-1:0] x_im;
  logic signed [W_BF-1:0] y_re;
  logic signed [W_BF-1:0] y_im;

  // Sign extend by one bit for growth
  assign x_re = W_BF'(x.re);
  assign x_im = W_BF'(x.im);
  assign y_re = W_BF'(y.re);
  assign y_im = W_BF'(y.im);

  always_ff @(posedge clk) begin
    if (rst) begin
      sum  <= '0;
      diff <= '0;
    end else begin
      sum.re  <= x_re + y_re;
      sum.im  <= x_im + y_im;
      diff.re <= x_re - y_re;
      diff.im <= x_im - y_im;
    end
  end

endmodule

//--- rtl/requant_sat.sv
module requant_sat (
  input  fft_types_pkg::cplx_bf_t  din,
  output fft_types_pkg::cplx_out_t dout
);

  import fft_stage_cfg_pkg::*;

  // Width left after dropping the extra fraction bits
  localparam int W_FL = W_BF - SHIFT;

  ////////////////////////////////////////////////////////////
  // Floor one component, then clamp to the output range
  ////////////////////////////////////////////////////////////
  function automatic logic signed [W_OUT-1:0] requant(
    input logic signed [W_BF-1:0] v
  );
    logic signed [W_FL-1:0]  fl;
    logic [W_FL-W_OUT:0]     top_bits;
    logic signed [W_OUT-1:0] res;

    // Dropping low bits of a two's complement value floors it
    fl       = v[W_BF-1:SHIFT];
    top_bits = fl[W_FL-1:W_OUT-1];

    // Discarded integer bits must all copy the sign
    if (top_bits == '0 || top_bits == '1) begin
      res = fl[W_OUT-1:0];
    end else if (fl[W_FL-1]) begin
      res = OUT_MIN;
    end else begin
      res = OUT_MAX;
    end
    return res;
  endfunction

  always_comb begin
    dout.re = requant(din.re);
    dout.im = requant(din.im);
  end

endmodule

//--- rtl/mdc_lane.sv
module mdc_lane (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    swap,
  input  fft_types_pkg::lane_in_t  din,
  output fft_types_pkg::lane_out_t dout
);

  import fft_types_pkg::*;

  cplx_in_t  bf_x;
  cplx_in_t  bf_y;
  cplx_bf_t  bf_sum;
  cplx_bf_t  bf_diff;
  cplx_out_t q_sum;
  cplx_out_t q_diff;

  ////////////////////////////////////////////////////////////
  // Reorder and butterfly
  ////////////////////////////////////////////////////////////
  delay_commutator comm_i (
    .clk  (clk),
    .rst  (rst),
    .swap (swap),
    .din  (din),
    .x    (bf_x),
    .y    (bf_y)
  );

  bfly_r2 bfly_i (
    .clk  (clk),
    .rst  (rst),
    .x    (bf_x),
    .y    (bf_y),
    .sum  (bf_sum),
    .diff (bf_diff)
  );

  ////////////////////////////////////////////////////////////
  // Requantize to Q6.4
  ////////////////////////////////////////////////////////////
  requant_sat sum_rq_i (
    .din  (bf_sum),
    .dout (q_sum)
  );

  requant_sat diff_rq_i (
    .din  (bf_diff),
    .dout (q_diff)
  );

  // Sum leaves on the up port, difference on the down port
  always_ff @(posedge clk) begin
    if (rst) begin
      dout <= '0;
    end else begin
      dout.up   <= q_sum;
      dout.down <= q_diff;
    end
  end

endmodule

//--- rtl/fft_last_stage_top.sv
module fft_last_stage_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_enable,
  input  fft_types_pkg::lane_in_t  lane0_in,
  input  fft_types_pkg::lane_in_t  lane1_in,
  output fft_types_pkg::lane_out_t lane0_out,
  output fft_types_pkg::lane_out_t lane1_out,
  output logic                    out_valid
);

  // Shared by both lanes
  logic swap;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////
  commutator_ctrl ctrl_i (
    .clk       (clk),
    .rst       (rst),
    .in_enable (in_enable),
    .swap      (swap),
    .out_valid (out_valid)
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////
  mdc_lane lane0_i (
    .clk  (clk),
    .rst  (rst),
    .swap (swap),
    .din  (lane0_in),
    .dout (lane0_out)
  );

  mdc_lane lane1_i (
    .clk  (clk),
    .rst  (rst),
    .swap (swap),
    .din  (lane1_in),
    .dout (lane1_out)
  );

endmodule

//--- testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One burst of the stimulus table
typedef struct packed {
  int up_re;
  int up_im;
  int dn_re;
  int dn_im;
  int step;       // ramp per sample plus LFSR noise when nonzero
  int l1_up_off;  // lane 1 up = lane 0 up + offset
  int l1_dn_off;  // lane 1 down = lane 0 down + offset
  int len;        // samples with in_enable high
  int gap;        // idle cycles after the burst
  int has_exp;    // constant sum expected where both samples come from this row
  int exp_re;
  int exp_im;
} burst_t;

localparam int N_BURSTS = 9;

// up_re, up_im, dn_re, dn_im, step, l1_up, l1_dn, len, gap, has_exp, exp_re, exp_im
localparam burst_t BURSTS [N_BURSTS] = '{
  '{0, 0, 0, 0, 1, 1000, -2000, 80, 0, 0, 0, 0},
  '{200000, -150000, -100000, 50000, -7, -3000, 4000, 50, 4, 0, 0, 0},
  '{0, 0, 0, 0, 5, 0, 0, 70, 0, 0, 0, 0},
  '{786432, -786432, 786432, -786432, 0, 0, 0, 48, 0, 1, 511, -512},
  '{523264, -524288, 523264, -524288, 0, 0, 0, 48, 0, 1, 511, -512},
  '{-1, 1023, -1, 1023, 0, 0, 0, 48, 0, 1, -1, 0},
  '{-1048576, 1048575, -1048576, 1048575, 0, 0, 0, 48, 2, 1, -512, 511},
  '{0, 5, 1, -3, 0, 2048, -2047, 48, 0, 0, 0, 0},
  '{400000, -400000, -400000, 400000, 11, 0, 0, 64, 0, 0, 0, 0}
};

`endif

//--- testbench/tb_fft_last_stage.sv
module tb_fft_last_stage;

  import fft_stage_cfg_pkg::*;
  import fft_types_pkg::*;

  `include "tb_vectors.svh"

  // Commutator delay, then the butterfly and output registers
  localparam int LAT      = COMM_DEPTH + 2;
  localparam int TIMEOUT  = 100;
  localparam int RND_BITS = 20;

  // Model sample tagged with the table row it came from or -1
  typedef struct packed {
    int re;
    int im;
    int tag;
  } smp_t;
  typedef smp_t [1:0] pair_t;

  localparam smp_t IDLE = '{re: 0, im: 0, tag: -1};

  logic        clk;
  logic        rst;
  logic        in_enable;
  lane_in_t    lane_in [2];
  lane_out_t   lane_out [2];
  logic        out_valid;
  int          in_tag;
  logic [31:0] lfsr_state;

  // Reference model state
  pair_t up_dq [$];
  pair_t upp_dq [$];
  logic  valid_dq [$];
  smp_t  bf_sum [2];
  smp_t  bf_diff [2];
  smp_t  q_sum [2];
  smp_t  q_diff [2];
  logic  swap_m;
  int    run_m;
  int    cnt_m;
  bit    model_live = 1'b0;
  int    const_hits = 0;

  fft_last_stage_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_enable (in_enable),
    .lane0_in  (lane_in[0]),
    .lane1_in  (lane_in[1]),
    .lane0_out (lane_out[0]),
    .lane1_out (lane_out[1]),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1
  function automatic int rand_bits(input int n);
    int   v;
    logic fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = (v << 1) | int'(fb);
    end
    return (v << (32 - n)) >>> (32 - n);
  endfunction

  // Floor to Q6.4, then clamp to the 10 bit range
  function automatic int floor_clamp(input int v);
    int s;
    int hi;
    int lo;
    hi = (1 << (W_OUT - 1)) - 1;
    lo = -(1 << (W_OUT - 1));
    s = v >>> (FRAC_IN - FRAC_OUT);
    if (s > hi) begin
      s = hi;
    end else if (s < lo) begin
      s = lo;
    end
    return s;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                          $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  task automatic reset_model();
    up_dq.delete();
    upp_dq.delete();
    valid_dq.delete();
    for (int i = 0; i < COMM_DEPTH; i++) begin
      up_dq.push_back({IDLE, IDLE});
      upp_dq.push_back({IDLE, IDLE});
    end
    for (int i = 0; i < LAT; i++) begin
      valid_dq.push_back(1'b0);
    end
    for (int l = 0; l < 2; l++) begin
      bf_sum[l]  = IDLE;
      bf_diff[l] = IDLE;
      q_sum[l]   = IDLE;
      q_diff[l]  = IDLE;
    end
    swap_m = 1'b0;
    run_m  = 0;
    cnt_m  = 0;
  endtask

  task automatic step_model();
    pair_t up_new;
    pair_t upp_new;
    smp_t  dn;
    smp_t  x;
    smp_t  y;
    int    t;
    for (int l = 0; l < 2; l++) begin
      up_new[l] = '{re: int'(lane_in[l].up.re), im: int'(lane_in[l].up.im), tag: in_tag};
      dn = '{re: int'(lane_in[l].down.re), im: int'(lane_in[l].down.im), tag: in_tag};
      x = upp_dq[0][l];
      // Commutator switch
      if (swap_m) begin
        upp_new[l] = dn;
        y = up_dq[0][l];
      end else begin
        upp_new[l] = up_dq[0][l];
        y = dn;
      end
      q_sum[l]  = '{re: floor_clamp(bf_sum[l].re), im: floor_clamp(bf_sum[l].im),
                    tag: bf_sum[l].tag};
      q_diff[l] = '{re: floor_clamp(bf_diff[l].re), im: floor_clamp(bf_diff[l].im),
                    tag: bf_diff[l].tag};
      t = (x.tag == y.tag) ? x.tag : -1;
      bf_sum[l]  = '{re: x.re + y.re, im: x.im + y.im, tag: t};
      bf_diff[l] = '{re: x.re - y.re, im: x.im - y.im, tag: t};
    end
    void'(up_dq.pop_front());
    up_dq.push_back(up_new);
    void'(upp_dq.pop_front());
    upp_dq.push_back(upp_new);
    void'(valid_dq.pop_front());
    valid_dq.push_back(in_enable);
    // Phase count restarts with every enabled run
    if (!in_enable) begin
      run_m  = 0;
      cnt_m  = 0;
      swap_m = 1'b0;
    end else if (run_m < COMM_DEPTH) begin
      run_m++;
    end else begin
      if (cnt_m == COMM_DEPTH - 1) begin
        swap_m = !swap_m;
      end
      cnt_m = (cnt_m + 1) % COMM_DEPTH;
    end
  endtask

  task automatic compare_outputs();
    burst_t b;
    string  pfx;
    check_value("out_valid", int'(out_valid), int'(valid_dq[0]));
    for (int l = 0; l < 2; l++) begin
      pfx = $sformatf("lane%0d_out", l);
      check_value({pfx, ".up.re"}, int'(lane_out[l].up.re), q_sum[l].re);
      check_value({pfx, ".up.im"}, int'(lane_out[l].up.im), q_sum[l].im);
      check_value({pfx, ".down.re"}, int'(lane_out[l].down.re), q_diff[l].re);
      check_value({pfx, ".down.im"}, int'(lane_out[l].down.im), q_diff[l].im);
      // Both samples from a constant row with a known result
      if (q_sum[l].tag >= 0) begin
        b = BURSTS[q_sum[l].tag];
        if (b.has_exp != 0) begin
          check_value({pfx, ".up.re const"}, int'(lane_out[l].up.re), b.exp_re);
          check_value({pfx, ".up.im const"}, int'(lane_out[l].up.im), b.exp_im);
          check_value({pfx, ".down.re const"}, int'(lane_out[l].down.re), 0);
          check_value({pfx, ".down.im const"}, int'(lane_out[l].down.im), 0);
          const_hits++;
        end
      end
    end
  endtask

  always @(posedge clk) begin
    if (model_live) begin
      compare_outputs();
    end
    if (rst) begin
      reset_model();
      model_live = 1'b1;
    end else if (model_live) begin
      step_model();
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic drive_sample(input burst_t b, input int r, input int i);
    int       v [4];
    lane_in_t s0;
    lane_in_t s1;
    v[0] = b.up_re + b.step * i;
    v[1] = b.up_im + b.step * i;
    v[2] = b.dn_re + b.step * i;
    v[3] = b.dn_im + b.step * i;
    if (b.step != 0) begin
      for (int k = 0; k < 4; k++) begin
        v[k] = v[k] + rand_bits(RND_BITS);
      end
    end
    s0.up.re   = W_IN'(v[0]);
    s0.up.im   = W_IN'(v[1]);
    s0.down.re = W_IN'(v[2]);
    s0.down.im = W_IN'(v[3]);
    s1.up.re   = W_IN'(v[0] + b.l1_up_off);
    s1.up.im   = W_IN'(v[1] + b.l1_up_off);
    s1.down.re = W_IN'(v[2] + b.l1_dn_off);
    s1.down.im = W_IN'(v[3] + b.l1_dn_off);
    lane_in[0] <= s0;
    lane_in[1] <= s1;
    in_enable  <= 1'b1;
    in_tag     <= r;
  endtask

  task automatic drive_idle();
    lane_in[0] <= '0;
    lane_in[1] <= '0;
    in_enable  <= 1'b0;
    in_tag     <= -1;
  endtask

  // Counts cycles until out_valid reaches level
  task automatic wait_valid(input logic level, input bit zero_out, output int cycles);
    cycles = 0;
    @(posedge clk);
    while (out_valid !== level) begin
      if (zero_out) begin
        check_value("lane0_out nonzero", int'(|lane_out[0]), 0);
        check_value("lane1_out nonzero", int'(|lane_out[1]), 0);
      end
      cycles++;
      if (cycles > TIMEOUT) begin
        if (level) begin
          abort_run("Timeout: out_valid never rose");
        end else begin
          abort_run("Timeout: out_valid never fell");
        end
      end
      @(posedge clk);
    end
  endtask

  initial begin
    int n;
    rst        <= 1'b1;
    in_enable  <= 1'b0;
    lane_in[0] <= '0;
    lane_in[1] <= '0;
    in_tag     <= -1;
    lfsr_state = 32'h4d6b_7873;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Latency of out_valid with zero data
    @(posedge clk);
    in_enable <= 1'b1;
    wait_valid(1'b1, 1'b1, n);
    check_value("out_valid rise delay", n, LAT);
    in_enable <= 1'b0;
    wait_valid(1'b0, 1'b0, n);
    check_value("out_valid fall delay", n, LAT);

    for (int r = 0; r < N_BURSTS; r++) begin
      for (int i = 0; i < BURSTS[r].len; i++) begin
        @(posedge clk);
        drive_sample(BURSTS[r], r, i);
      end
      for (int g = 0; g < BURSTS[r].gap; g++) begin
        @(posedge clk);
        drive_idle();
      end
    end
    @(posedge clk);
    drive_idle();
    wait_valid(1'b0, 1'b0, n);

    if (const_hits == 0) begin
      abort_run("No output of a constant row reached the checker");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

//--- flist.f
+incdir+testbench
rtl/fft_stage_cfg_pkg.sv
rtl/fft_types_pkg.sv
rtl/delay_line.sv
rtl/commutator_ctrl.sv
rtl/delay_commutator.sv
rtl/bfly_r2.sv
rtl/requant_sat.sv
rtl/mdc_lane.sv
rtl/fft_last_stage_top.sv
testbench/tb_fft_last_stage.sv

//--- Makefile
TOP = tb_fft_last_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
